//--- env_bank.sv
`default_nettype none

`include "synth_params.svh"

module env_bank (
    input  wire                        osc_clk,
    input  wire                        reset_reg_N,
    input  wire                        sclk_xvxenvs,
    input  wire [`SYNTH_VOICES-1:0]    gate,
    output logic [`SYNTH_VOICES*$bits(synth_pkg::env_level_t)-1:0] env_levels
);

    import synth_pkg::*;

    localparam int LVL_W = $bits(env_level_t);
    localparam voice_idx_t VOICE_LAST = voice_idx_t'(`SYNTH_VOICES - 1);
    localparam env_level_t LVL_MAX = '1;
    localparam env_level_t ATK_STEP = env_level_t'(`ENV_ATTACK_STEP);
    localparam env_level_t REL_STEP = env_level_t'(`ENV_RELEASE_STEP);

    env_state_t env_state [`SYNTH_VOICES];
    env_level_t env_level [`SYNTH_VOICES];
    voice_idx_t vptr;
    logic       sclk_q;
    logic       env_tick;

    assign env_tick = sclk_xvxenvs & ~sclk_q;

    //////////////////////////////////////////////////
    // round robin envelope update
    //////////////////////////////////////////////////
    always_ff @(posedge osc_clk)
    begin
        if (!reset_reg_N)
        begin
            sclk_q <= 1'b0;
            vptr <= '0;
            for (int v = 0; v < `SYNTH_VOICES; v++)
            begin
                env_state[v] <= ENV_IDLE;
                env_level[v] <= '0;
            end
        end
        else
        begin
            sclk_q <= sclk_xvxenvs;
            if (env_tick)
            begin
                vptr <= (vptr == VOICE_LAST) ? '0 : vptr + 1'b1;
                if (gate[vptr])
                begin
                    // attack, saturate at full scale
                    if (env_state[vptr] != ENV_SUSTAIN)
                    begin
                        if (env_level[vptr] >= LVL_MAX - ATK_STEP)
                        begin
                            env_level[vptr] <= LVL_MAX;
                            env_state[vptr] <= ENV_SUSTAIN;
                        end
                        else
                        begin
                            env_level[vptr] <= env_level[vptr] + ATK_STEP;
                            env_state[vptr] <= ENV_ATTACK;
                        end
                    end
                end
                else if (env_state[vptr] != ENV_IDLE)
                begin
                    // release, floor at zero
                    if (env_level[vptr] <= REL_STEP)
                    begin
                        env_level[vptr] <= '0;
                        env_state[vptr] <= ENV_IDLE;
                    end
                    else
                    begin
                        env_level[vptr] <= env_level[vptr] - REL_STEP;
                        env_state[vptr] <= ENV_RELEASE;
                    end
                end
            end
        end
    end

    // flatten, voice 0 in low byte
    always_comb
    begin
        for (int v = 0; v < `SYNTH_VOICES; v++)
            env_levels[v*LVL_W +: LVL_W] = env_level[v];
    end

endmodule

`default_nettype wire

//--- osc_bank.sv
`default_nettype none

`include "synth_params.svh"

module osc_bank (
    input  wire                   osc_clk,
    input  wire                   reset_reg_N,
    input  wire                   sclk_xvxosc,
    input  wire                   inc_wr,
    input  wire synth_pkg::voice_idx_t inc_voice,
    input  wire synth_pkg::osc_idx_t   inc_osc,
    input  wire synth_pkg::phase_t     inc_value,
    output logic                  slot_valid,
    output synth_pkg::voice_idx_t slot_voice,
    output synth_pkg::sample_t    slot_sample
);

    import synth_pkg::*;

    localparam int SLOTS = `SYNTH_VOICES * `SYNTH_V_OSC;
    localparam int SLOT_W = $clog2(SLOTS);
    localparam int OSC_W = $clog2(`SYNTH_V_OSC);
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(SLOTS - 1);
    localparam int PH_W = $bits(phase_t);
    localparam int SMP_W = $bits(sample_t);

    // per-slot tables, voice-major order
    phase_t inc_mem [SLOTS];
    phase_t phase_mem [SLOTS];

    logic [SLOT_W-1:0] slot_cnt;
    logic [SLOT_W-1:0] wr_slot;
    logic              sclk_q;
    logic              osc_tick;

    // slow level rose since last cycle
    assign osc_tick = sclk_xvxosc & ~sclk_q;
    // host address into the table
    assign wr_slot = {inc_voice, inc_osc};

    //////////////////////////////////////////////////
    // slot sequencer and phase update
    //////////////////////////////////////////////////
    always_ff @(posedge osc_clk)
    begin
        if (!reset_reg_N)
        begin
            sclk_q <= 1'b0;
            slot_cnt <= '0;
            slot_valid <= 1'b0;
            for (int i = 0; i < SLOTS; i++)
            begin
                inc_mem[i] <= '0;
                phase_mem[i] <= '0;
            end
        end
        else
        begin
            sclk_q <= sclk_xvxosc;
            slot_valid <= osc_tick;
            // old increment still used if same slot is visited now
            if (inc_wr)
                inc_mem[wr_slot] <= inc_value;
            if (osc_tick)
            begin
                phase_mem[slot_cnt] <= phase_mem[slot_cnt] + inc_mem[slot_cnt];
                if (slot_cnt == SLOT_LAST)
                    slot_cnt <= '0;
                else
                    slot_cnt <= slot_cnt + 1'b1;
            end
        end
    end

    // sample from the phase before this update
    always_ff @(posedge osc_clk)
    begin
        if (osc_tick)
        begin
            slot_voice <= slot_cnt[SLOT_W-1:OSC_W];
            slot_sample <= sample_t'(phase_mem[slot_cnt][PH_W-1 -: SMP_W]);
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line in the log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module synth_tb -o synth_sim \
    > build.log 2>&1 \
    && ./obj_dir/synth_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^No errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- synth_clk_gen.sv
`default_nettype none

`include "synth_params.svh"

module synth_clk_gen (
    input  wire  osc_clk,
    input  wire  reset_reg_N,
    output logic sclk_xvxosc,
    output logic sclk_xvxenvs
);

    // wide enough to hold the divider value itself
    localparam int XVOSC_W = $clog2(`XVOSC_DIV + 1);
    localparam int XVXENVS_W = $clog2(`XVXENVS_DIV + 1);

    localparam logic [XVOSC_W-1:0] XVOSC_LIM = XVOSC_W'(`XVOSC_DIV);
    localparam logic [XVXENVS_W-1:0] XVXENVS_LIM = XVXENVS_W'(`XVXENVS_DIV);

    logic [XVOSC_W-1:0] xvosc_cnt;
    logic [XVXENVS_W-1:0] xvxenvs_cnt;

    //////////////////////////////////////////////////
    // half period counters
    //////////////////////////////////////////////////
    always_ff @(posedge osc_clk)
    begin
        if (!reset_reg_N)
        begin
            xvosc_cnt <= '0;
            xvxenvs_cnt <= '0;
            sclk_xvxosc <= 1'b0;
            sclk_xvxenvs <= 1'b0;
        end
        else
        begin
            // oscillator slot pace
            if (xvosc_cnt >= XVOSC_LIM)
            begin
                // counter restarts at 1
                xvosc_cnt <= XVOSC_W'(1);
                sclk_xvxosc <= ~sclk_xvxosc;
            end
            else
                xvosc_cnt <= xvosc_cnt + 1'b1;

            // envelope update pace
            if (xvxenvs_cnt >= XVXENVS_LIM)
            begin
                xvxenvs_cnt <= XVXENVS_W'(1);
                sclk_xvxenvs <= ~sclk_xvxenvs;
            end
            else
                xvxenvs_cnt <= xvxenvs_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- synth_params.svh
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// voice layout
`define SYNTH_VOICES 8
// oscillators per voice
`define SYNTH_V_OSC 4

//////////////////////////////////////////////////
// divider values
// osc_clk cycles per half period of the slow levels
//////////////////////////////////////////////////
`define XVOSC_DIV 3
`define XVXENVS_DIV 5

// envelope steps per update
`define ENV_ATTACK_STEP 32
`define ENV_RELEASE_STEP 16

`endif

//--- synth_pkg.sv
`default_nettype none

package synth_pkg;

    // voice number
    typedef logic [2:0] voice_idx_t;
    // oscillator within a voice
    typedef logic [1:0] osc_idx_t;

    // phase accumulator and increment
    typedef logic [15:0] phase_t;
    // sawtooth sample, top byte of phase
    typedef logic signed [7:0] sample_t;

    // envelope level, 255 is full scale
    typedef logic [7:0] env_level_t;
    // scaled sample times level
    typedef logic signed [15:0] prod_t;
    // sum over one round of 32 slots
    typedef logic signed [20:0] mix_t;

    // per-voice envelope fsm
    typedef enum logic [1:0] {
        ENV_IDLE,
        ENV_ATTACK,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_t;

endpackage

`default_nettype wire

//--- synth_tb.sv
`default_nettype none

`include "synth_params.svh"

module synth_tb;

    import synth_pkg::*;

    localparam int VOICES = `SYNTH_VOICES;
    localparam int OSCS = `SYNTH_V_OSC;
    localparam int SLOTS = VOICES * OSCS;
    // frame period is 32 ticks of 6 cycles
    localparam int FRAME_TIMEOUT = 400;

    logic osc_clk;
    logic reset_reg_N;
    logic inc_wr;
    voice_idx_t inc_voice;
    osc_idx_t inc_osc;
    phase_t inc_value;
    logic [VOICES-1:0] gate;
    wire sclk_xvxosc;
    wire sclk_xvxenvs;
    wire frame_valid;
    mix_t frame_mix;

    int seed = 32'h42f773d8;
    // stimulus modes
    bit rand_wr;
    bit rand_gate;
    bit zero_mix;

    // reference model state
    int m_cnt_osc;
    int m_cnt_env;
    bit m_sclk_osc;
    bit m_sclk_env;
    bit m_q_osc;
    bit m_q_env;
    int m_slot;
    bit m_slot_valid;
    int m_slot_num;
    int m_slot_voice;
    int m_slot_sample;
    int m_phase [SLOTS];
    int m_inc [SLOTS];
    int m_level [VOICES];
    int m_vptr;
    int m_acc;
    int m_mix;
    bit m_fv;

    synth_top u_synth_top (
        .osc_clk      (osc_clk),
        .reset_reg_N  (reset_reg_N),
        .inc_wr       (inc_wr),
        .inc_voice    (inc_voice),
        .inc_osc      (inc_osc),
        .inc_value    (inc_value),
        .gate         (gate),
        .sclk_xvxosc  (sclk_xvxosc),
        .sclk_xvxenvs (sclk_xvxenvs),
        .frame_valid  (frame_valid),
        .frame_mix    (frame_mix)
    );

    initial
    begin
        osc_clk = 1'b0;
        forever
            #20 osc_clk = ~osc_clk;
    end

    //////////////////////////////////////////////////
    // error handling and compare tasks
    //////////////////////////////////////////////////
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_run($sformatf("error at time %0t: %s is %b, expected %b",
                               $time, what, got, exp));
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_run($sformatf("error at time %0t: %s is %b, expected %b",
                               $time, what, got, exp));
    endtask

    task automatic check_mix(input mix_t got, input mix_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("error at time %0t: %s is %0d, expected %0d",
                               $time, what, got, exp));
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    task automatic model_reset();
        m_cnt_osc = 0;
        m_cnt_env = 0;
        m_sclk_osc = 1'b0;
        m_sclk_env = 1'b0;
        m_q_osc = 1'b0;
        m_q_env = 1'b0;
        m_slot = 0;
        m_slot_valid = 1'b0;
        m_slot_num = 0;
        m_vptr = 0;
        m_acc = 0;
        m_mix = 0;
        m_fv = 1'b0;
        for (int i = 0; i < SLOTS; i++)
        begin
            m_phase[i] = 0;
            m_inc[i] = 0;
        end
        for (int v = 0; v < VOICES; v++)
            m_level[v] = 0;
    endtask

    // one osc_clk cycle
    // consumers run first and see last cycle's values
    task automatic model_step();
        int prod;
        int top;
        bit o_tick;
        bit e_tick;
        // mixer product floors sample times level over 256
        m_fv = 1'b0;
        if (m_slot_valid)
        begin
            prod = (m_slot_sample * m_level[m_slot_voice]) >>> 8;
            if (m_slot_num == SLOTS - 1)
            begin
                m_fv = 1'b1;
                m_mix = m_acc + prod;
                m_acc = 0;
            end
            else
                m_acc = m_acc + prod;
        end
        // envelope ramps linearly between clamps
        e_tick = m_sclk_env && !m_q_env;
        m_q_env = m_sclk_env;
        if (e_tick)
        begin
            if (gate[m_vptr])
                m_level[m_vptr] = (m_level[m_vptr] + `ENV_ATTACK_STEP > 255) ?
                                  255 : m_level[m_vptr] + `ENV_ATTACK_STEP;
            else
                m_level[m_vptr] = (m_level[m_vptr] < `ENV_RELEASE_STEP) ?
                                  0 : m_level[m_vptr] - `ENV_RELEASE_STEP;
            m_vptr = (m_vptr + 1) % VOICES;
        end
        // oscillator slot samples the phase before the add
        o_tick = m_sclk_osc && !m_q_osc;
        m_q_osc = m_sclk_osc;
        m_slot_valid = o_tick;
        if (o_tick)
        begin
            top = (m_phase[m_slot] >> 8) & 255;
            m_slot_sample = (top >= 128) ? top - 256 : top;
            m_slot_voice = m_slot / OSCS;
            m_slot_num = m_slot;
            m_phase[m_slot] = (m_phase[m_slot] + m_inc[m_slot]) & 16'hffff;
            m_slot = (m_slot + 1) % SLOTS;
        end
        // host write lands after this cycle's slot read
        if (inc_wr)
            m_inc[int'(inc_voice) * OSCS + int'(inc_osc)] = int'(inc_value);
        // dividers reload 1 and toggle
        if (m_cnt_osc >= `XVOSC_DIV)
        begin
            m_cnt_osc = 1;
            m_sclk_osc = !m_sclk_osc;
        end
        else
            m_cnt_osc++;
        if (m_cnt_env >= `XVXENVS_DIV)
        begin
            m_cnt_env = 1;
            m_sclk_env = !m_sclk_env;
        end
        else
            m_cnt_env++;
    endtask

    // an osc tick lands in the coming cycle
    function automatic bit tick_due();
        return m_sclk_osc && !m_q_osc;
    endfunction

    //////////////////////////////////////////////////
    // cycle stepping and stimulus
    //////////////////////////////////////////////////
    task automatic drive_inputs();
        int r;
        r = $random(seed);
        inc_wr = 1'b0;
        if (!tick_due())
        begin
            if (rand_wr && (r[3:0] == 4'd0))
            begin
                inc_wr = 1'b1;
                inc_voice = voice_idx_t'($random(seed));
                inc_osc = osc_idx_t'($random(seed));
                inc_value = phase_t'($random(seed));
            end
            if (rand_gate && (r[9:4] == 6'd0))
                gate = gate ^ (8'd1 << r[12:10]);
        end
    endtask

    task automatic step_cycle();
        @(posedge osc_clk);
        #1;
        model_step();
        check_level(sclk_xvxosc, m_sclk_osc, "sclk_xvxosc");
        check_level(sclk_xvxenvs, m_sclk_env, "sclk_xvxenvs");
        check_valid(frame_valid, m_fv, "frame_valid");
        if (m_fv)
        begin
            check_mix(frame_mix, mix_t'(m_mix), "frame_mix");
            if (zero_mix)
                check_mix(frame_mix, '0, "frame_mix with all gates low");
        end
        drive_inputs();
    endtask

    task automatic wait_frame();
        int waited;
        waited = 0;
        step_cycle();
        while (!frame_valid && waited <= FRAME_TIMEOUT)
        begin
            step_cycle();
            waited++;
        end
        if (!frame_valid)
            fail_run("timeout: no frame arrived while waiting for frame_valid");
    endtask

    // directed write held for one cycle
    task automatic write_inc(input int v, input int o, input int val);
        inc_voice = voice_idx_t'(v);
        inc_osc = osc_idx_t'(o);
        inc_value = phase_t'(val);
        inc_wr = 1'b1;
        step_cycle();
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial
    begin
        reset_reg_N = 1'b0;
        inc_wr = 1'b0;
        inc_voice = '0;
        inc_osc = '0;
        inc_value = '0;
        gate = '0;
        rand_wr = 1'b0;
        rand_gate = 1'b0;
        zero_mix = 1'b0;
        model_reset();
        repeat (4)
            @(posedge osc_clk);
        #1;
        reset_reg_N = 1'b1;

        // voice 2 ramps up then down on a single oscillator
        write_inc(2, 1, 16'h1234);
        gate = 8'b0000_0100;
        repeat (6)
            wait_frame();
        gate = '0;
        repeat (10)
            wait_frame();

        // silent frames with gates low and random increments
        zero_mix = 1'b1;
        rand_wr = 1'b1;
        repeat (4)
            wait_frame();
        zero_mix = 1'b0;

        // random gates and increments
        rand_gate = 1'b1;
        gate = VOICES'($random(seed));
        repeat (24)
            wait_frame();

        // one mid-run write with everything else steady
        rand_wr = 1'b0;
        rand_gate = 1'b0;
        gate = '1;
        repeat (3)
            wait_frame();
        write_inc(5, 3, 16'h4321);
        repeat (3)
            wait_frame();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- synth_top.sv
`default_nettype none

`include "synth_params.svh"

module synth_top (
    input  wire                        osc_clk,
    input  wire                        reset_reg_N,
    input  wire                        inc_wr,
    input  wire synth_pkg::voice_idx_t inc_voice,
    input  wire synth_pkg::osc_idx_t   inc_osc,
    input  wire synth_pkg::phase_t     inc_value,
    input  wire [`SYNTH_VOICES-1:0]    gate,
    output wire                        sclk_xvxosc,
    output wire                        sclk_xvxenvs,
    output wire                        frame_valid,
    output wire synth_pkg::mix_t       frame_mix
);

    import synth_pkg::*;

    // oscillator to mixer slot stream
    wire             slot_valid;
    wire voice_idx_t slot_voice;
    wire sample_t    slot_sample;
    // all voice levels, voice 0 low
    wire [`SYNTH_VOICES*$bits(env_level_t)-1:0] env_levels;

    //////////////////////////////////////////////////
    // pacing, oscillators, envelopes, mix
    //////////////////////////////////////////////////
    synth_clk_gen u_synth_clk_gen (
        .osc_clk      (osc_clk),
        .reset_reg_N  (reset_reg_N),
        .sclk_xvxosc  (sclk_xvxosc),
        .sclk_xvxenvs (sclk_xvxenvs)
    );

    osc_bank u_osc_bank (
        .osc_clk     (osc_clk),
        .reset_reg_N (reset_reg_N),
        .sclk_xvxosc (sclk_xvxosc),
        .inc_wr      (inc_wr),
        .inc_voice   (inc_voice),
        .inc_osc     (inc_osc),
        .inc_value   (inc_value),
        .slot_valid  (slot_valid),
        .slot_voice  (slot_voice),
        .slot_sample (slot_sample)
    );

    env_bank u_env_bank (
        .osc_clk      (osc_clk),
        .reset_reg_N  (reset_reg_N),
        .sclk_xvxenvs (sclk_xvxenvs),
        .gate         (gate),
        .env_levels   (env_levels)
    );

    voice_mixer u_voice_mixer (
        .osc_clk     (osc_clk),
        .reset_reg_N (reset_reg_N),
        .slot_valid  (slot_valid),
        .slot_voice  (slot_voice),
        .slot_sample (slot_sample),
        .env_levels  (env_levels),
        .frame_valid (frame_valid),
        .frame_mix   (frame_mix)
    );

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
synth_pkg.sv
synth_clk_gen.sv
osc_bank.sv
env_bank.sv
voice_mixer.sv
synth_top.sv
synth_tb.sv

//--- voice_mixer.sv
`default_nettype none

`include "synth_params.svh"

module voice_mixer (
    input  wire                        osc_clk,
    input  wire                        reset_reg_N,
    input  wire                        slot_valid,
    input  wire synth_pkg::voice_idx_t slot_voice,
    input  wire synth_pkg::sample_t    slot_sample,
    input  wire [`SYNTH_VOICES*$bits(synth_pkg::env_level_t)-1:0] env_levels,
    output logic                       frame_valid,
    output synth_pkg::mix_t            frame_mix
);

    import synth_pkg::*;

    localparam int LVL_W = $bits(env_level_t);
    localparam int SMP_W = $bits(sample_t);
    localparam int SLOTS = `SYNTH_VOICES * `SYNTH_V_OSC;
    localparam int SLOT_W = $clog2(SLOTS);
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(SLOTS - 1);

    env_level_t                 cur_level;
    logic signed [SMP_W+LVL_W:0] full_prod;
    prod_t                      scaled;
    mix_t                       acc;
    mix_t                       acc_next;
    logic [SLOT_W-1:0]          slot_cnt;
    logic                       frame_end;

    //////////////////////////////////////////////////
    // scale sample by its voice envelope
    //////////////////////////////////////////////////
    assign cur_level = env_levels[slot_voice*LVL_W +: LVL_W];
    // level zero-extended so it stays positive
    assign full_prod = slot_sample * $signed({1'b0, cur_level});
    assign scaled = prod_t'(full_prod >>> LVL_W);
    assign acc_next = acc + mix_t'(scaled);
    // own slot count marks voice 7 osc 3
    assign frame_end = slot_valid && (slot_cnt == SLOT_LAST);

    always_ff @(posedge osc_clk)
    begin
        if (!reset_reg_N)
        begin
            slot_cnt <= '0;
            acc <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            frame_valid <= frame_end;
            if (frame_end)
            begin
                slot_cnt <= '0;
                acc <= '0;
            end
            else if (slot_valid)
            begin
                slot_cnt <= slot_cnt + 1'b1;
                acc <= acc_next;
            end
        end
    end

    // frame result, last product included
    always_ff @(posedge osc_clk)
    begin
        if (frame_end)
            frame_mix <= acc_next;
    end

endmodule

`default_nettype wire
